//--- Makefile
VERILATOR ?= verilator
TOP       ?= dma_wh_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
logic/dma_wh_pkg.sv
logic/two_slot_fifo.sv
logic/dma_to_wormhole.sv
logic/wh_mem_endpoint.sv
logic/link_route_regs.sv
logic/dma_wh_top.sv
bench/dma_wh_tb.sv

//--- bench/dma_wh_tb.sv
// testbench for the DMA to wormhole subsystem
// drives the Wishbone and DMA ports and checks fill data against a reference memory
`timescale 1ns/1ns

module dma_wh_tb
  import dma_wh_pkg::*;
();

  localparam int TIMEOUT    = 2000;
  localparam int WB_TIMEOUT = 8;
  localparam int LINE_SHIFT = 4;
  localparam int LINE_BITS  = $clog2(MEM_LINES);

  logic     clk_i = 1'b0;
  logic     reset_i;
  dma_pkt_s dma_pkt_i;
  logic     dma_pkt_v_i;
  logic     dma_pkt_yumi_o;
  flit_t    dma_wdata_i;
  logic     dma_wdata_v_i;
  logic     dma_wdata_yumi_o;
  flit_t    dma_rdata_o;
  logic     dma_rdata_v_o;
  logic     dma_rdata_ready_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_adr_t  wb_adr_i;
  wb_word_t wb_dat_i;
  wb_word_t wb_dat_o;
  logic     wb_ack_o;

  dma_pkt_s    pkt_q[$];
  flit_t       wdata_q[$];
  flit_t       fill_q[$];
  int          accept_cyc[$];
  flit_t       ref_mem [MEM_LINES][BURST_LEN];
  cord_t       dest_cord;
  logic        jitter = 1'b0;
  logic        ack_seen = 1'b0;
  int          cycle = 0;

  dma_wh_top u_dma_wh_top (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_with_failure($sformatf("ERR %s expected %h got %h", name, exp, act));
  endtask

  assert property (@(posedge clk_i) disable iff (reset_i) dma_pkt_yumi_o |-> dma_pkt_v_i)
    else stop_with_failure("packet yumi raised without packet valid");
  assert property (@(posedge clk_i) disable iff (reset_i) dma_wdata_yumi_o |-> dma_wdata_v_i)
    else stop_with_failure("write-data yumi raised without write-data valid");

  // ack is a single-cycle pulse
  always @(posedge clk_i) begin
    if (!reset_i) begin
      assert (!(ack_seen && wb_ack_o))
        else stop_with_failure("wb_ack_o stayed high for more than one cycle");
    end
    ack_seen <= wb_ack_o;
  end

  // head of the packet queue stays on the port until taken
  always @(posedge clk_i) begin
    if (dma_pkt_v_i && dma_pkt_yumi_o) begin
      pkt_q.delete(0);
      accept_cyc.push_back(cycle);
    end
    #1;
    dma_pkt_v_i = (pkt_q.size() != 0);
    if (pkt_q.size() != 0) dma_pkt_i = pkt_q[0];
  end

  // write data valid toggles randomly when jitter is on
  always @(posedge clk_i) begin
    if (dma_wdata_v_i && dma_wdata_yumi_o) wdata_q.delete(0);
    #1;
    if (wdata_q.size() != 0) begin
      dma_wdata_v_i = jitter ? 1'($urandom_range(1, 0)) : 1'b1;
      dma_wdata_i   = wdata_q[0];
    end else begin
      dma_wdata_v_i = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    #1;
    dma_rdata_ready_i = jitter ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  // every accepted fill beat must be the oldest expected one
  always @(posedge clk_i) begin
    if (!reset_i && dma_rdata_v_o && dma_rdata_ready_i) begin
      assert (fill_q.size() != 0)
        else stop_with_failure("fill beat delivered while no beat was expected");
      check_word("dma_rdata_o", fill_q[0], dma_rdata_o);
      fill_q.delete(0);
    end
  end

  task automatic wb_access(input logic we, input wb_adr_t adr, input wb_word_t dat,
                           output wb_word_t rdat);
    int n;
    n = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WB_TIMEOUT) stop_with_failure("timed out waiting for wb_ack_o");
    end while (!wb_ack_o);
    rdat = wb_dat_o;
    assert (n == 2) else stop_with_failure("wb_ack_o did not follow the first edge of the access");
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic set_dest(input cord_t cord);
    wb_word_t unused_rd;
    wb_access(1'b1, REG_DEST_CORD, wb_word_t'(cord), unused_rd);
    dest_cord = cord;
  endtask

  // random upper and offset bits with the line index at bit 4
  function automatic addr_t line_addr(input int line);
    addr_t a;
    a = addr_t'($urandom);
    a[LINE_SHIFT +: LINE_BITS] = LINE_BITS'(line);
    return a;
  endfunction

  task automatic issue_write(input int line);
    dma_pkt_s p;
    flit_t    d;
    int       b;
    p.write_not_read = 1'b1;
    p.addr = line_addr(line);
    pkt_q.push_back(p);
    for (b = 0; b < BURST_LEN; b++) begin
      d = $urandom;
      wdata_q.push_back(d);
      if (dest_cord == ENDPOINT_CORD) ref_mem[line][b] = d;
    end
  endtask

  task automatic issue_read(input int line);
    dma_pkt_s p;
    int       b;
    p.write_not_read = 1'b0;
    p.addr = line_addr(line);
    pkt_q.push_back(p);
    for (b = 0; b < BURST_LEN; b++) fill_q.push_back(ref_mem[line][b]);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (pkt_q.size() != 0 || wdata_q.size() != 0 || fill_q.size() != 0) begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT) stop_with_failure("timed out waiting for DMA traffic to drain");
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    wb_word_t rd;
    wb_word_t val;
    wb_word_t mask;
    int       idx;
    int       line;
    void'($urandom(32'hbf29));
    reset_i           = 1'b1;
    wb_cyc_i          = 1'b0;
    wb_stb_i          = 1'b0;
    wb_we_i           = 1'b0;
    wb_adr_i          = '0;
    wb_dat_i          = '0;
    dma_pkt_i         = '0;
    dma_pkt_v_i       = 1'b0;
    dma_wdata_i       = '0;
    dma_wdata_v_i     = 1'b0;
    dma_rdata_ready_i = 1'b1;
    dest_cord         = '0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_word("wb_ack_o", 32'h0, 32'(wb_ack_o));
    check_word("dma_rdata_v_o", 32'h0, 32'(dma_rdata_v_o));
    check_word("dma_wdata_yumi_o", 32'h0, 32'(dma_wdata_yumi_o));

    // route registers come out of reset at zero
    for (idx = 0; idx < 4; idx++) begin
      wb_access(1'b0, wb_adr_t'(idx), '0, rd);
      check_word("wb_dat_o", 32'h0, rd);
    end
    for (idx = 0; idx < 4; idx++) begin
      val  = $urandom;
      mask = (idx == REG_MY_CORD || idx == REG_DEST_CORD) ? (1 << CORD_W) - 1
                                                          : (1 << CID_W) - 1;
      wb_access(1'b1, wb_adr_t'(idx), val, rd);
      wb_access(1'b0, wb_adr_t'(idx), '0, rd);
      check_word("wb_dat_o", val & mask, rd);
    end

    wb_access(1'b1, REG_MY_CORD, 32'h3, rd);
    wb_access(1'b1, REG_MY_CID, 32'h2, rd);
    wb_access(1'b1, REG_DEST_CID, 32'h1, rd);
    set_dest(ENDPOINT_CORD);

    // bursts to several lines and then read back
    for (line = 2; line < MEM_LINES; line += 3) issue_write(line);
    for (line = 2; line < MEM_LINES; line += 3) issue_read(line);
    wait_idle();

    // write and read offered back to back
    accept_cyc.delete();
    issue_write(3);
    issue_read(5);
    wait_idle();
    assert (accept_cyc.size() == 2 && accept_cyc[1] == accept_cyc[0] + 1)
      else stop_with_failure("write and read packets were not accepted on consecutive cycles");

    // random stalls on write data and fill ready
    jitter = 1'b1;
    for (idx = 0; idx < 8; idx++) begin
      line = $urandom_range(MEM_LINES - 1, 0);
      issue_write(line);
      issue_read(line);
      issue_read(2);
    end
    wait_idle();
    jitter = 1'b0;

    // a burst to another coordinate is dropped by the endpoint
    set_dest(cord_t'(ENDPOINT_CORD + 5));
    issue_write(8);
    wait_idle();
    set_dest(ENDPOINT_CORD);
    issue_read(8);
    issue_read(2);
    wait_idle();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- logic/dma_to_wormhole.sv
// bridge between the cache DMA port and the wormhole link
// sends header, address and write data; returns fill beats to the cache
`timescale 1ns/1ns

module dma_to_wormhole
  import dma_wh_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  wh_route_s route_i,
  input  dma_pkt_s  dma_pkt_i,
  input  logic      dma_pkt_v_i,
  output logic      dma_pkt_yumi_o,
  input  flit_t     dma_wdata_i,
  input  logic      dma_wdata_v_i,
  output logic      dma_wdata_yumi_o,
  output flit_t     dma_rdata_o,
  output logic      dma_rdata_v_o,
  input  logic      dma_rdata_ready_i,
  output logic      req_v_o,
  output flit_t     req_flit_o,
  input  logic      req_ready_i,
  input  logic      rsp_v_i,
  input  flit_t     rsp_flit_i,
  output logic      rsp_ready_o
);

  typedef enum logic [1:0] {SEND_RESET, SEND_HEADER, SEND_ADDR, SEND_DATA} send_state_e;
  typedef enum logic [1:0] {RECV_RESET, RECV_HEADER, RECV_DATA} recv_state_e;

  dma_pkt_s    pkt;
  logic        pkt_ready;
  logic        pkt_v;
  logic        pkt_yumi;
  flit_t       ret_flit;
  logic        ret_v;
  logic        ret_ready;
  logic        ret_yumi;
  wh_header_s  header;
  send_state_e send_state_r, send_state_n;
  recv_state_e recv_state_r, recv_state_n;
  beat_t       send_cnt_r, send_cnt_n;
  beat_t       recv_cnt_r, recv_cnt_n;

  // packet buffer keeps a writeback and the following fill back to back
  two_slot_fifo #(.elem_t(dma_pkt_s)) u_pkt_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (dma_pkt_v_i),
    .data_i  (dma_pkt_i),
    .ready_o (pkt_ready),
    .v_o     (pkt_v),
    .data_o  (pkt),
    .yumi_i  (pkt_yumi)
  );

  assign dma_pkt_yumi_o = pkt_ready & dma_pkt_v_i;

  two_slot_fifo #(.elem_t(flit_t)) u_ret_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (rsp_v_i),
    .data_i  (rsp_flit_i),
    .ready_o (rsp_ready_o),
    .v_o     (ret_v),
    .data_o  (ret_flit),
    .yumi_i  (ret_yumi)
  );

  assign ret_yumi = ret_ready & ret_v;

  always_comb begin
    header                = '0;
    header.write_not_read = pkt.write_not_read;
    header.src_cid        = route_i.my_cid;
    header.src_cord       = route_i.my_cord;
    header.len            = pkt.write_not_read ? WRITE_LEN : READ_LEN;
    header.cid            = route_i.dest_cid;
    header.cord           = route_i.dest_cord;
  end

  always_comb begin
    send_state_n     = send_state_r;
    send_cnt_n       = send_cnt_r;
    pkt_yumi         = 1'b0;
    req_v_o          = 1'b0;
    req_flit_o       = dma_wdata_i;
    dma_wdata_yumi_o = 1'b0;
    case (send_state_r)
      SEND_RESET: send_state_n = SEND_HEADER;
      SEND_HEADER: begin
        req_flit_o = flit_t'(header);
        req_v_o    = pkt_v;
        if (pkt_v && req_ready_i) send_state_n = SEND_ADDR;
      end
      SEND_ADDR: begin
        req_flit_o = flit_t'(pkt.addr);
        req_v_o    = pkt_v;
        // packet leaves the buffer with its address flit
        pkt_yumi   = pkt_v & req_ready_i;
        if (pkt_yumi) begin
          send_cnt_n   = '0;
          send_state_n = pkt.write_not_read ? SEND_DATA : SEND_HEADER;
        end
      end
      SEND_DATA: begin
        req_v_o          = dma_wdata_v_i;
        dma_wdata_yumi_o = dma_wdata_v_i & req_ready_i;
        if (dma_wdata_yumi_o) begin
          send_cnt_n = send_cnt_r + 1'b1;
          if (send_cnt_r == LAST_BEAT) send_state_n = SEND_HEADER;
        end
      end
      default: send_state_n = SEND_HEADER;
    endcase
  end

  always_comb begin
    recv_state_n  = recv_state_r;
    recv_cnt_n    = recv_cnt_r;
    ret_ready     = 1'b0;
    dma_rdata_v_o = 1'b0;
    dma_rdata_o   = ret_flit;
    case (recv_state_r)
      RECV_RESET: recv_state_n = RECV_HEADER;
      RECV_HEADER: begin
        // response header carries nothing the cache needs
        ret_ready = 1'b1;
        if (ret_v) begin
          recv_cnt_n   = '0;
          recv_state_n = RECV_DATA;
        end
      end
      RECV_DATA: begin
        ret_ready     = dma_rdata_ready_i;
        dma_rdata_v_o = ret_v;
        if (ret_v && dma_rdata_ready_i) begin
          recv_cnt_n = recv_cnt_r + 1'b1;
          if (recv_cnt_r == LAST_BEAT) recv_state_n = RECV_HEADER;
        end
      end
      default: recv_state_n = RECV_HEADER;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_RESET;
      recv_state_r <= RECV_RESET;
      send_cnt_r   <= '0;
      recv_cnt_r   <= '0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      send_cnt_r   <= send_cnt_n;
      recv_cnt_r   <= recv_cnt_n;
    end
  end

endmodule

//--- logic/dma_wh_pkg.sv
// shared widths, constants and packet types for the DMA to wormhole path
// imported by every module of the subsystem
package dma_wh_pkg;

  localparam int FLIT_W    = 32;
  localparam int ADDR_W    = 28;
  localparam int BURST_LEN = 4;
  localparam int CORD_W    = 4;
  localparam int CID_W     = 2;
  localparam int LEN_W     = 4;
  localparam int MEM_LINES = 16;

  localparam int BEAT_W    = $clog2(BURST_LEN);
  localparam int LINE_W    = $clog2(MEM_LINES);
  // byte offset inside one line of BURST_LEN words
  localparam int LINE_LSB  = $clog2(BURST_LEN * FLIT_W / 8);
  localparam int HDR_PAD_W = FLIT_W - 1 - 2 * CID_W - 2 * CORD_W - LEN_W;
  localparam int WB_ADR_W  = 4;
  localparam int WB_DATA_W = 32;

  typedef logic [FLIT_W-1:0]    flit_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [CORD_W-1:0]    cord_t;
  typedef logic [CID_W-1:0]     cid_t;
  typedef logic [LEN_W-1:0]     len_t;
  typedef logic [BEAT_W-1:0]    beat_t;
  typedef logic [LINE_W-1:0]    line_t;
  typedef logic [WB_ADR_W-1:0]  wb_adr_t;
  typedef logic [WB_DATA_W-1:0] wb_word_t;

  localparam cord_t ENDPOINT_CORD = cord_t'(1);
  localparam beat_t LAST_BEAT     = beat_t'(BURST_LEN - 1);

  // flits after the header: address plus data, address only, fill data
  localparam len_t WRITE_LEN = len_t'(BURST_LEN + 1);
  localparam len_t READ_LEN  = len_t'(1);
  localparam len_t RESP_LEN  = len_t'(BURST_LEN);

  // host register word indices
  localparam wb_adr_t REG_MY_CORD   = wb_adr_t'(0);
  localparam wb_adr_t REG_MY_CID    = wb_adr_t'(1);
  localparam wb_adr_t REG_DEST_CORD = wb_adr_t'(2);
  localparam wb_adr_t REG_DEST_CID  = wb_adr_t'(3);

  typedef struct packed {
    logic  write_not_read;
    addr_t addr;
  } dma_pkt_s;

  typedef struct packed {
    logic [HDR_PAD_W-1:0] unused;
    logic                 write_not_read;
    cid_t                 src_cid;
    cord_t                src_cord;
    len_t                 len;
    cid_t                 cid;
    cord_t                cord;
  } wh_header_s;

  typedef struct packed {
    cord_t my_cord;
    cid_t  my_cid;
    cord_t dest_cord;
    cid_t  dest_cid;
  } wh_route_s;

endpackage

//--- logic/dma_wh_top.sv
// closed-loop subsystem: route registers, DMA bridge and memory endpoint
`timescale 1ns/1ns

module dma_wh_top
  import dma_wh_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  dma_pkt_s dma_pkt_i,
  input  logic     dma_pkt_v_i,
  output logic     dma_pkt_yumi_o,
  input  flit_t    dma_wdata_i,
  input  logic     dma_wdata_v_i,
  output logic     dma_wdata_yumi_o,
  output flit_t    dma_rdata_o,
  output logic     dma_rdata_v_o,
  input  logic     dma_rdata_ready_i,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_adr_t  wb_adr_i,
  input  wb_word_t wb_dat_i,
  output wb_word_t wb_dat_o,
  output logic     wb_ack_o
);

  wh_route_s route;
  logic      req_v;
  flit_t     req_flit;
  logic      req_ready;
  logic      rsp_v;
  flit_t     rsp_flit;
  logic      rsp_ready;

  link_route_regs u_link_route_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .route_o  (route)
  );

  dma_to_wormhole u_dma_to_wormhole (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .route_i           (route),
    .dma_pkt_i         (dma_pkt_i),
    .dma_pkt_v_i       (dma_pkt_v_i),
    .dma_pkt_yumi_o    (dma_pkt_yumi_o),
    .dma_wdata_i       (dma_wdata_i),
    .dma_wdata_v_i     (dma_wdata_v_i),
    .dma_wdata_yumi_o  (dma_wdata_yumi_o),
    .dma_rdata_o       (dma_rdata_o),
    .dma_rdata_v_o     (dma_rdata_v_o),
    .dma_rdata_ready_i (dma_rdata_ready_i),
    .req_v_o           (req_v),
    .req_flit_o        (req_flit),
    .req_ready_i       (req_ready),
    .rsp_v_i           (rsp_v),
    .rsp_flit_i        (rsp_flit),
    .rsp_ready_o       (rsp_ready)
  );

  wh_mem_endpoint u_wh_mem_endpoint (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v),
    .req_flit_i  (req_flit),
    .req_ready_o (req_ready),
    .rsp_v_o     (rsp_v),
    .rsp_flit_o  (rsp_flit),
    .rsp_ready_i (rsp_ready)
  );

endmodule

//--- logic/link_route_regs.sv
// Wishbone classic register block holding the bridge's route fields
// one ack cycle per access, writes land on the ack edge
`timescale 1ns/1ns

module link_route_regs
  import dma_wh_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  wb_adr_t   wb_adr_i,
  input  wb_word_t  wb_dat_i,
  output wb_word_t  wb_dat_o,
  output logic      wb_ack_o,
  output wh_route_s route_o
);

  wh_route_s route_r;
  logic      ack_r;
  logic      access;

  // ack_r term forces a gap cycle when stb stays high
  assign access   = wb_cyc_i & wb_stb_i & ~ack_r;
  assign wb_ack_o = ack_r;
  assign route_o  = route_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      route_r <= '0;
      ack_r   <= 1'b0;
    end else begin
      ack_r <= access;
      if (access && wb_we_i) begin
        case (wb_adr_i)
          REG_MY_CORD:   route_r.my_cord   <= wb_dat_i[CORD_W-1:0];
          REG_MY_CID:    route_r.my_cid    <= wb_dat_i[CID_W-1:0];
          REG_DEST_CORD: route_r.dest_cord <= wb_dat_i[CORD_W-1:0];
          REG_DEST_CID:  route_r.dest_cid  <= wb_dat_i[CID_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (wb_adr_i)
      REG_MY_CORD:   wb_dat_o = wb_word_t'(route_r.my_cord);
      REG_MY_CID:    wb_dat_o = wb_word_t'(route_r.my_cid);
      REG_DEST_CORD: wb_dat_o = wb_word_t'(route_r.dest_cord);
      REG_DEST_CID:  wb_dat_o = wb_word_t'(route_r.dest_cid);
      default:       wb_dat_o = '0;
    endcase
  end

endmodule

//--- logic/two_slot_fifo.sv
// two-entry valid/ready buffer, accepts a new entry while the oldest leaves
`timescale 1ns/1ns

module two_slot_fifo
  import dma_wh_pkg::*;
#(
  parameter type elem_t = dma_pkt_s
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  v_i,
  input  elem_t data_i,
  output logic  ready_o,
  output logic  v_o,
  output elem_t data_o,
  input  logic  yumi_i
);

  elem_t slot_r [2];
  logic  wptr_r;
  logic  rptr_r;
  logic  full_r;
  logic  empty_r;
  logic  enq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = slot_r[rptr_r];
  assign enq     = v_i & ~full_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq) wptr_r <= ~wptr_r;
      if (yumi_i) rptr_r <= ~rptr_r;
      // occupancy only moves when exactly one side fires
      if (enq && !yumi_i) begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end else if (yumi_i && !enq) begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) slot_r[wptr_r] <= data_i;
  end

endmodule

//--- logic/wh_mem_endpoint.sv
// wormhole memory target at ENDPOINT_CORD
// stores write bursts, answers read bursts, drops packets for other coordinates
`timescale 1ns/1ns

module wh_mem_endpoint
  import dma_wh_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_v_i,
  input  flit_t req_flit_i,
  output logic  req_ready_o,
  output logic  rsp_v_o,
  output flit_t rsp_flit_o,
  input  logic  rsp_ready_i
);

  typedef enum logic [2:0] {
    EP_HEADER, EP_ADDR, EP_WDATA, EP_DROP, EP_RHEADER, EP_RDATA
  } ep_state_e;

  ep_state_e  state_r;
  beat_t      beat_r;
  len_t       drop_r;
  line_t      line_r;
  logic       wnr_r;
  cord_t      src_cord_r;
  cid_t       src_cid_r;
  wh_header_s hdr_in;
  wh_header_s rsp_hdr;
  logic       req_fire;
  logic       rsp_fire;
  flit_t      mem_r [MEM_LINES*BURST_LEN];
  logic [LINE_W+BEAT_W-1:0] mem_idx;

  assign hdr_in      = wh_header_s'(req_flit_i);
  assign rsp_v_o     = (state_r == EP_RHEADER) || (state_r == EP_RDATA);
  assign req_ready_o = ~rsp_v_o;
  assign req_fire    = req_v_i & req_ready_o;
  assign rsp_fire    = rsp_v_o & rsp_ready_i;
  assign mem_idx     = {line_r, beat_r};

  // reply goes back to whoever asked
  always_comb begin
    rsp_hdr          = '0;
    rsp_hdr.src_cord = ENDPOINT_CORD;
    rsp_hdr.len      = RESP_LEN;
    rsp_hdr.cid      = src_cid_r;
    rsp_hdr.cord     = src_cord_r;
  end

  assign rsp_flit_o = (state_r == EP_RHEADER) ? flit_t'(rsp_hdr) : mem_r[mem_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= EP_HEADER;
      beat_r  <= '0;
      drop_r  <= '0;
    end else begin
      case (state_r)
        EP_HEADER: if (req_fire) begin
          if (hdr_in.cord != ENDPOINT_CORD) begin
            drop_r <= hdr_in.len;
            if (hdr_in.len != '0) state_r <= EP_DROP;
          end else begin
            wnr_r      <= hdr_in.write_not_read;
            src_cord_r <= hdr_in.src_cord;
            src_cid_r  <= hdr_in.src_cid;
            state_r    <= EP_ADDR;
          end
        end
        EP_ADDR: if (req_fire) begin
          line_r  <= req_flit_i[LINE_LSB +: LINE_W];
          beat_r  <= '0;
          state_r <= wnr_r ? EP_WDATA : EP_RHEADER;
        end
        EP_WDATA: if (req_fire) begin
          beat_r <= beat_r + 1'b1;
          if (beat_r == LAST_BEAT) state_r <= EP_HEADER;
        end
        EP_DROP: if (req_fire) begin
          drop_r <= drop_r - 1'b1;
          if (drop_r == len_t'(1)) state_r <= EP_HEADER;
        end
        EP_RHEADER: if (rsp_fire) state_r <= EP_RDATA;
        EP_RDATA: if (rsp_fire) begin
          beat_r <= beat_r + 1'b1;
          if (beat_r == LAST_BEAT) state_r <= EP_HEADER;
        end
        default: state_r <= EP_HEADER;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == EP_WDATA && req_fire) mem_r[mem_idx] <= req_flit_i;
  end

endmodule
